// File: cache_types_pkg.sv
`default_nettype none

package cache_types_pkg;

    // ==================================================
    // widths and constants
    // ==================================================
    localparam int WORD_W            = 32;
    localparam int BYTE_OFF_BIT_LEN  = 2;
    localparam int BLOCK_OFF_BIT_LEN = 2;
    localparam int BLOCK_WORDS       = 4;
    localparam int INDEX_BIT_LEN     = 4;
    localparam int TAG_BIT_LEN       = 24;
    localparam int ADDR_W            = 32;
    localparam int UUID_SIZE         = 8;

    typedef logic [WORD_W-1:0]                  word_t;
    typedef logic [ADDR_W-1:0]                  addr_t;
    typedef logic [UUID_SIZE-1:0]               uuid_t;
    typedef logic [BLOCK_WORDS-1:0][WORD_W-1:0] block_t;   // word 0 sits in the low bits
    typedef logic [BLOCK_WORDS-1:0]             wmask_t;

    localparam uuid_t UUID_MAX = uuid_t'(255);  // counter wraps to 0 after this

    // ==================================================
    // request and entry records
    // ==================================================
    typedef struct packed {
        logic [TAG_BIT_LEN-1:0]       tag;
        logic [INDEX_BIT_LEN-1:0]     index;
        logic [BLOCK_OFF_BIT_LEN-1:0] block_offset;
        logic [BYTE_OFF_BIT_LEN-1:0]  byte_offset;
    } mem_addr_fields;

    typedef struct packed {
        mem_addr_fields addr;
        logic           rw_mode;       // 1 for a store
        word_t          store_value;
    } in_mem_instr;

    typedef struct packed {
        logic   valid;
        uuid_t  uuid;
        addr_t  block_addr;            // offsets are always zero here
        wmask_t write_status;
        block_t write_block;
    } mshr_reg;

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT,
        FILL
    } bank_state_t;

endpackage

`default_nettype wire

// File: cache_mshr_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module cache_mshr_buffer #(
    parameter int MSHR_BUFFER_LEN = 4
) (
    input  logic                         CLK,
    input  logic                         nRST,
    input  logic                         miss,
    input  cache_types_pkg::in_mem_instr mem_instr,
    input  logic                         bank_empty,
    output cache_types_pkg::mshr_reg     mshr_out,
    output logic                         stall,
    output cache_types_pkg::uuid_t       uuid_out
);
    import cache_types_pkg::*;

    localparam int LAST = MSHR_BUFFER_LEN - 1;

    mshr_reg [LAST:0]   slots;
    mshr_reg [LAST:0]   next_slots;
    mshr_reg [LAST:0]   merged;       // slots after a secondary miss is folded in
    logic    [LAST-1:0] hit;
    logic    [LAST:0]   open;         // slot is empty or its entry leaves this cycle
    mshr_reg            cand;
    uuid_t              uuid_cnt;
    uuid_t              next_uuid;
    logic               secondary;
    logic               primary;
    logic               accept;

    // ==================================================
    // candidate entry from the incoming request
    // ==================================================
    always_comb begin
        cand            = '0;
        cand.valid      = 1'b1;
        cand.uuid       = next_uuid;
        cand.block_addr = {mem_instr.addr.tag, mem_instr.addr.index,
                           (BLOCK_OFF_BIT_LEN + BYTE_OFF_BIT_LEN)'(0)};
        if (mem_instr.rw_mode) begin
            cand.write_status[mem_instr.addr.block_offset] = 1'b1;
            cand.write_block[mem_instr.addr.block_offset]  = mem_instr.store_value;
        end
    end

    // the last slot is left out of the search since the bank may take it this cycle
    always_comb begin
        merged = slots;
        for (int i = 0; i < LAST; i++) begin
            hit[i] = miss && slots[i].valid && (slots[i].block_addr == cand.block_addr);
            if (hit[i]) begin
                merged[i].write_status = slots[i].write_status | cand.write_status;
                if (mem_instr.rw_mode) begin
                    merged[i].write_block[mem_instr.addr.block_offset] =
                        mem_instr.store_value;
                end
            end
        end
    end

    // a slot can take the entry behind it once the slot ahead makes room
    always_comb begin
        open[LAST] = !slots[LAST].valid || bank_empty;
        for (int j = LAST - 1; j >= 0; j--) begin
            open[j] = !slots[j].valid || open[j+1];
        end
    end

    assign next_uuid = (uuid_cnt == UUID_MAX) ? '0 : uuid_cnt + 1'b1;
    assign secondary = |hit;
    assign primary   = miss && !secondary;
    assign accept    = primary && open[0];
    assign stall     = primary && !open[0];         // secondaries never wait
    assign uuid_out  = accept ? next_uuid : slots[0].uuid;
    assign mshr_out  = slots[LAST];

    // ==================================================
    // queue update
    // ==================================================
    always_comb begin
        if (open[0]) begin
            next_slots[0] = accept ? cand : '0;
        end else begin
            next_slots[0] = merged[0];
        end
        for (int j = 1; j <= LAST; j++) begin
            next_slots[j] = open[j] ? merged[j-1] : merged[j];
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            slots    <= '0;
            uuid_cnt <= '0;
        end else begin
            slots <= next_slots;
            if (accept) begin
                uuid_cnt <= next_uuid;   // only a primary that got a slot uses up an id
            end
        end
    end

endmodule

`default_nettype wire

// File: cache_bank.sv
`timescale 1ns/100ps
`default_nettype none

module cache_bank (
    input  logic                     CLK,
    input  logic                     nRST,
    input  cache_types_pkg::mshr_reg mshr_out,
    output logic                     bank_empty,
    output logic                     mem_req,
    output cache_types_pkg::addr_t   mem_addr,
    input  logic                     mem_ready,
    input  cache_types_pkg::block_t  mem_rdata,
    output logic                     fill_valid,
    output cache_types_pkg::uuid_t   fill_uuid,
    output cache_types_pkg::addr_t   fill_addr,
    output cache_types_pkg::block_t  fill_block,
    output cache_types_pkg::wmask_t  fill_wmask
);
    import cache_types_pkg::*;

    bank_state_t state;
    bank_state_t next_state;
    uuid_t       cur_uuid;
    addr_t       cur_addr;
    wmask_t      cur_wmask;
    block_t      cur_wdata;
    block_t      merged_block;
    block_t      fill_data;
    logic        take;

    assign take = (state == IDLE) && mshr_out.valid;   // buffer shifts on the same edge

    // ==================================================
    // state machine
    // ==================================================
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (take) begin
                    next_state = REQ;
                end
            end
            REQ: begin
                next_state = WAIT;   // one read request per entry
            end
            WAIT: begin
                if (mem_ready) begin
                    next_state = FILL;
                end
            end
            FILL: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ==================================================
    // entry capture and store merge
    // ==================================================
    always_ff @(posedge CLK) begin
        if (take) begin
            cur_uuid  <= mshr_out.uuid;
            cur_addr  <= mshr_out.block_addr;
            cur_wmask <= mshr_out.write_status;
            cur_wdata <= mshr_out.write_block;
        end
    end

    // pending store words win over what memory returns
    always_comb begin
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            merged_block[w] = cur_wmask[w] ? cur_wdata[w] : mem_rdata[w];
        end
    end

    always_ff @(posedge CLK) begin
        if ((state == WAIT) && mem_ready) begin
            fill_data <= merged_block;
        end
    end

    assign bank_empty = (state == IDLE);
    assign mem_req    = (state == REQ);
    assign mem_addr   = cur_addr;
    assign fill_valid = (state == FILL);
    assign fill_uuid  = cur_uuid;
    assign fill_addr  = cur_addr;
    assign fill_block = fill_data;
    assign fill_wmask = cur_wmask;

endmodule

`default_nettype wire

// File: cache_miss_unit.sv
`timescale 1ns/100ps
`default_nettype none

module cache_miss_unit #(
    parameter int MSHR_BUFFER_LEN = 4
) (
    input  logic                         CLK,
    input  logic                         nRST,

    // miss port from the cache pipeline
    input  logic                         miss,
    input  cache_types_pkg::in_mem_instr mem_instr,
    output logic                         stall,
    output cache_types_pkg::uuid_t       uuid_out,

    // block read port to memory
    output logic                         mem_req,
    output cache_types_pkg::addr_t       mem_addr,
    input  logic                         mem_ready,
    input  cache_types_pkg::block_t      mem_rdata,

    // filled block back to the cache
    output logic                         fill_valid,
    output cache_types_pkg::uuid_t       fill_uuid,
    output cache_types_pkg::addr_t       fill_addr,
    output cache_types_pkg::block_t      fill_block,
    output cache_types_pkg::wmask_t      fill_wmask
);
    import cache_types_pkg::*;

    mshr_reg mshr_out;      // oldest queue entry offered to the bank
    logic    bank_empty;

    cache_mshr_buffer #(
        .MSHR_BUFFER_LEN (MSHR_BUFFER_LEN)
    ) mshr_buffer_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .miss       (miss),
        .mem_instr  (mem_instr),
        .bank_empty (bank_empty),
        .mshr_out   (mshr_out),
        .stall      (stall),
        .uuid_out   (uuid_out)
    );

    cache_bank bank_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .mshr_out   (mshr_out),
        .bank_empty (bank_empty),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .fill_valid (fill_valid),
        .fill_uuid  (fill_uuid),
        .fill_addr  (fill_addr),
        .fill_block (fill_block),
        .fill_wmask (fill_wmask)
    );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model #(
    parameter int                     MEM_LATENCY = 6,
    parameter int                     DRIVE_DELAY = 10,
    parameter cache_types_pkg::word_t MEM_XOR     = 32'h5A5A_C3C3
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    mem_req,
    input  cache_types_pkg::addr_t  mem_addr,
    output logic                    mem_ready,
    output cache_types_pkg::block_t mem_rdata
);
    import cache_types_pkg::*;

    logic  busy;
    int    count;
    addr_t req_addr;

    // every word holds its own word address folded with a constant
    function automatic block_t block_data(input addr_t blk);
        block_t b;
        for (int w = 0; w < BLOCK_WORDS; w++) begin
            b[w] = word_t'((blk >> BYTE_OFF_BIT_LEN) + w) ^ MEM_XOR;
        end
        return b;
    endfunction

    // ==================================================
    // one read at a time, answered after MEM_LATENCY cycles
    // ==================================================
    initial begin
        mem_ready = 1'b0;
        mem_rdata = '0;
        busy      = 1'b0;
        count     = 0;
        req_addr  = '0;
        forever begin
            @(posedge CLK);
            #(DRIVE_DELAY);
            mem_ready = 1'b0;      // ready is a single cycle pulse
            mem_rdata = '0;
            if (!nRST) begin
                busy = 1'b0;
            end else if (busy) begin
                if (count == 1) begin
                    mem_ready = 1'b1;
                    mem_rdata = block_data(req_addr);
                    busy      = 1'b0;
                end else begin
                    count = count - 1;
                end
            end else if (mem_req) begin
                busy     = 1'b1;
                req_addr = mem_addr;
                count    = MEM_LATENCY;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_cache_miss_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cache_miss_unit;
    import cache_types_pkg::*;

    localparam int    CLK_PERIOD      = 100;
    localparam int    DRIVE_DELAY     = 10;
    localparam int    MSHR_LEN        = 4;
    localparam int    MEM_LATENCY     = 6;
    localparam word_t MEM_XOR         = 32'h5A5A_C3C3;
    localparam int    RAND_SEED       = 42943;
    localparam int    PRESSURE_MISSES = 40;
    localparam int    WRAP_MISSES     = 260;
    localparam int    NUM_MISSES      = 1 + 1 + (MSHR_LEN + 3) + PRESSURE_MISSES + WRAP_MISSES;
    localparam int    WATCHDOG_CYCLES = (NUM_MISSES + 4) * (MEM_LATENCY + 8);

    logic        CLK;
    logic        nRST;
    logic        miss;
    in_mem_instr mem_instr;
    logic        stall;
    uuid_t       uuid_out;
    logic        mem_req;
    addr_t       mem_addr;
    logic        mem_ready;
    block_t      mem_rdata;
    logic        fill_valid;
    uuid_t       fill_uuid;
    addr_t       fill_addr;
    block_t      fill_block;
    wmask_t      fill_wmask;

    // one row per accepted miss, secondaries under the uuid of their block
    uuid_t  log_uuid[$];
    addr_t  log_addr[$];
    logic   log_rw[$];
    word_t  log_value[$];
    uuid_t  pending_uuid[$];     // primaries waiting for a fill, oldest first
    addr_t  pending_addr[$];

    uuid_t  uuid_next;
    uuid_t  last_primary;
    uuid_t  last_fill_uuid;
    wmask_t last_fill_mask;
    int     fill_count;
    int     primary_count;
    int     stall_cycles;
    int     block_seq;
    logic   saw_wrap;

    cache_miss_unit #(
        .MSHR_BUFFER_LEN (MSHR_LEN)
    ) cache_miss_unit_i (
        .CLK        (CLK),
        .nRST       (nRST),
        .miss       (miss),
        .mem_instr  (mem_instr),
        .stall      (stall),
        .uuid_out   (uuid_out),
        .mem_req    (mem_req),
        .mem_addr   (mem_addr),
        .mem_ready  (mem_ready),
        .mem_rdata  (mem_rdata),
        .fill_valid (fill_valid),
        .fill_uuid  (fill_uuid),
        .fill_addr  (fill_addr),
        .fill_block (fill_block),
        .fill_wmask (fill_wmask)
    );

    tb_mem_model #(
        .MEM_LATENCY (MEM_LATENCY),
        .DRIVE_DELAY (DRIVE_DELAY),
        .MEM_XOR     (MEM_XOR)
    ) mem_model_i (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_req   (mem_req),
        .mem_addr  (mem_addr),
        .mem_ready (mem_ready),
        .mem_rdata (mem_rdata)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ==================================================
    // failure reporting and compare tasks
    // ==================================================
    task automatic stop_failed();
        $display("tests failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic show_error(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic fail_because(input string msg);
        $display("%s", msg);
        stop_failed();
    endtask

    task automatic check_uuid(input uuid_t got, input uuid_t want, input string what);
        if (got !== want) begin
            show_error($sformatf("%s: got %0d, expected %0d", what, got, want));
        end
    endtask

    task automatic check_addr(input addr_t got, input addr_t want, input string what);
        if (got !== want) begin
            show_error($sformatf("%s: got %h, expected %h", what, got, want));
        end
    endtask

    task automatic check_block(input block_t got, input block_t want, input string what);
        if (got !== want) begin
            show_error($sformatf("%s: got %h, expected %h", what, got, want));
        end
    endtask

    task automatic check_mask(input wmask_t got, input wmask_t want, input string what);
        if (got !== want) begin
            show_error($sformatf("%s: got %b, expected %b", what, got, want));
        end
    endtask

    // ==================================================
    // reference model
    // ==================================================
    function automatic addr_t block_of(input addr_t a);
        return {a[ADDR_W-1:4], 4'b0000};
    endfunction

    // memory block first, then every logged store of this miss in order
    function automatic block_t expected_fill(input uuid_t u, input addr_t blk,
                                             output wmask_t mask);
        block_t b;
        int     w;
        mask = '0;
        for (int i = 0; i < BLOCK_WORDS; i++) begin
            b[i] = word_t'((blk >> 2) + i) ^ MEM_XOR;
        end
        for (int k = 0; k < log_uuid.size(); k++) begin
            if (log_uuid[k] == u && block_of(log_addr[k]) == blk && log_rw[k]) begin
                w       = log_addr[k][3:2];
                b[w]    = log_value[k];
                mask[w] = 1'b1;
            end
        end
        return b;
    endfunction

    // the sequence number in the tag keeps every block distinct
    function automatic addr_t fresh_addr(input logic [1:0] word);
        word_t       r;
        logic [15:0] seq16;
        r         = $urandom;
        seq16     = block_seq[15:0];
        block_seq = block_seq + 1;
        return {r[31:24], seq16, r[3:0], word, 2'b00};
    endfunction

    // ==================================================
    // stimulus helpers
    // ==================================================
    task automatic step_to_drive();
        @(posedge CLK);
        #(DRIVE_DELAY);
    endtask

    task automatic send_miss(input addr_t a, input logic rw, input word_t v,
                             input logic secondary, input uuid_t target);
        logic  taken;
        uuid_t got;
        taken                 = 1'b0;
        got                   = '0;
        miss                  = 1'b1;
        mem_instr.addr        = a;
        mem_instr.rw_mode     = rw;
        mem_instr.store_value = v;
        while (!taken) begin
            @(negedge CLK);
            if (stall && secondary) begin
                show_error("a secondary miss was stalled");
            end else if (stall) begin
                stall_cycles = stall_cycles + 1;
                step_to_drive();          // hold the request until there is room
            end else begin
                got   = uuid_out;
                taken = 1'b1;
            end
        end
        log_uuid.push_back(secondary ? target : got);
        log_addr.push_back(a);
        log_rw.push_back(rw);
        log_value.push_back(v);
        if (secondary) begin
            check_uuid(got, target, "uuid shown for a secondary miss");
        end else begin
            check_uuid(got, uuid_next, "uuid given to a primary miss");
            pending_uuid.push_back(got);
            pending_addr.push_back(block_of(a));
            primary_count = primary_count + 1;
            last_primary  = got;
            uuid_next     = (uuid_next == UUID_MAX) ? uuid_t'(0) : uuid_t'(uuid_next + 1);
        end
        step_to_drive();
    endtask

    task automatic end_burst();
        miss      = 1'b0;
        mem_instr = '0;
    endtask

    task automatic send_random_misses(input int count);
        word_t r;
        word_t v;
        addr_t a;
        for (int n = 0; n < count; n++) begin
            r = $urandom;
            v = $urandom;
            a = fresh_addr(r[1:0]);
            send_miss(a, r[2], v, 1'b0, '0);
        end
        end_burst();
    endtask

    // drain, then stay quiet long enough for a stray fill to show up
    task automatic finish_test(input string name);
        while (pending_uuid.size() != 0) begin
            @(negedge CLK);
        end
        repeat (MEM_LATENCY + 8) @(negedge CLK);
        if (fill_count != primary_count) begin
            fail_because($sformatf("%s: %0d fills for %0d primary misses",
                                   name, fill_count, primary_count));
        end
        $display("%s done at %0t, %0d fills so far", name, $time, fill_count);
        step_to_drive();
    endtask

    // ==================================================
    // fill monitor
    // ==================================================
    always @(negedge CLK) begin : fill_compare
        uuid_t  want_uuid;
        addr_t  want_addr;
        block_t want_block;
        wmask_t want_mask;
        if (nRST === 1'b1 && fill_valid === 1'b1) begin
            if (pending_uuid.size() == 0) begin
                show_error("fill arrived with no accepted miss waiting for it");
            end else begin
                want_uuid  = pending_uuid.pop_front();
                want_addr  = pending_addr.pop_front();
                want_block = expected_fill(want_uuid, want_addr, want_mask);
                check_uuid(fill_uuid, want_uuid, "fill uuid");
                check_addr(fill_addr, want_addr, "fill address");
                check_block(fill_block, want_block, "fill block");
                check_mask(fill_wmask, want_mask, "fill mask");
                if (fill_count > 0 && last_fill_uuid == UUID_MAX && fill_uuid == '0) begin
                    saw_wrap = 1'b1;
                end
                last_fill_uuid = fill_uuid;
                last_fill_mask = fill_wmask;
                fill_count     = fill_count + 1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        fail_because($sformatf("run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    // ==================================================
    // test sequence
    // ==================================================
    initial begin : stimulus
        addr_t a;
        uuid_t tgt;
        int    stall_before;
        CLK           = 1'b0;
        nRST          = 1'b0;
        miss          = 1'b0;
        mem_instr     = '0;
        uuid_next     = uuid_t'(1);
        last_primary  = '0;
        fill_count    = 0;
        primary_count = 0;
        stall_cycles  = 0;
        block_seq     = 1;
        saw_wrap      = 1'b0;
        void'($urandom(RAND_SEED));
        repeat (2) @(posedge CLK);
        #(DRIVE_DELAY);
        nRST = 1'b1;

        // reset values, then one load miss
        @(negedge CLK);
        if (stall !== 1'b0 || mem_req !== 1'b0 || fill_valid !== 1'b0) begin
            show_error("stall, mem_req or fill_valid is not low after reset");
        end
        step_to_drive();
        a = fresh_addr(2'd2);
        send_miss(a, 1'b0, '0, 1'b0, '0);
        end_burst();
        finish_test("reset and load miss");
        check_uuid(last_fill_uuid, uuid_t'(1), "first fill uuid");
        check_mask(last_fill_mask, wmask_t'(0), "load miss mask");

        // single store to word 3
        a = fresh_addr(2'd3);
        send_miss(a, 1'b1, 32'h1357_9BDF, 1'b0, '0);
        end_burst();
        finish_test("store miss");
        check_mask(last_fill_mask, 4'b1000, "store miss mask");

        // fillers take the bank and the upper slots, so the stored block stays in slot 0
        stall_before = stall_cycles;
        for (int n = 0; n < MSHR_LEN; n++) begin
            a = fresh_addr(2'd0);
            send_miss(a, 1'b0, '0, 1'b0, '0);
        end
        a = fresh_addr(2'd1);
        send_miss(a, 1'b1, 32'h2468_ACE0, 1'b0, '0);
        tgt = last_primary;
        send_miss({a[ADDR_W-1:4], 2'd3, 2'b00}, 1'b1, 32'h0F1E_2D3C, 1'b1, tgt);
        send_miss({a[ADDR_W-1:4], 2'd0, 2'b00}, 1'b0, '0, 1'b1, tgt);
        end_burst();
        if (stall_cycles != stall_before) begin
            fail_because("stall rose while stores were merged into one block");
        end
        finish_test("secondary store merge");
        check_mask(last_fill_mask, 4'b1010, "merged store mask");

        stall_before = stall_cycles;
        send_random_misses(PRESSURE_MISSES);
        if (stall_cycles == stall_before) begin
            fail_because("stall never rose while misses were driven back to back");
        end
        finish_test("back-pressure");

        send_random_misses(WRAP_MISSES);
        finish_test("uuid wrap");
        if (!saw_wrap) begin
            fail_because("fill uuid never went from its maximum back to zero");
        end

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: cache_miss_unit.f
cache_types_pkg.sv
cache_mshr_buffer.sv
cache_bank.sv
cache_miss_unit.sv
tb_mem_model.sv
tb_cache_miss_unit.sv
